//--- build.f
+incdir+source
source/lc3b_isa_pkg.sv
source/branch_ctrl_pkg.sv
source/fetch_branch_decode.sv
source/branch_history_counter.sv
source/branch_prediction_queue.sv
source/redirect_resolver.sv
source/lc3b_branch_unit.sv
tb/lc3b_branch_unit_tb.sv

//--- source/branch_ctrl_pkg.sv
`default_nettype none

`include "branch_params.svh"

package branch_ctrl_pkg;

    // next fetch address source.
    typedef enum logic [2:0] {
        pc_plus2           = 3'd0,
        alu                = 3'd1,
        pcn                = 3'd2,
        mdr                = 3'd3,
        branch_address     = 3'd4,
        mispredict_address = 3'd5
    } lc3b_pc_mux_sel;

    // predictor state, msb is the taken guess.
    typedef logic [`BP_COUNTER_BITS-1:0] bp_count_t;

    // read or write slot of the prediction queue.
    typedef logic [$clog2(`BP_QUEUE_DEPTH)-1:0] bp_qptr_t;

endpackage

`default_nettype wire

//--- source/branch_history_counter.sv
`timescale 1ns/1ps
`default_nettype none

module branch_history_counter (
    input  logic clk,
    input  logic rst_n,
    input  logic stall,

    input  logic train,
    input  logic train_taken,

    output logic predict_taken
);

    import branch_ctrl_pkg::*;

    bp_count_t count;

    // starts weakly not taken.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= bp_count_t'(1);
        end else if (!stall && train) begin
            if (train_taken) begin
                if (count != '1) begin
                    count <= count + bp_count_t'(1);
                end
            end else begin
                if (count != '0) begin
                    count <= count - bp_count_t'(1);
                end
            end
        end
    end

    assign predict_taken = count[$bits(bp_count_t)-1];

    // a resolving br must always be known at the edge.
    a_train_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(train)
    ) else $error("branch counter train is unknown");

endmodule

`default_nettype wire

//--- source/branch_params.svh
`ifndef BRANCH_PARAMS_SVH
`define BRANCH_PARAMS_SVH

// unresolved br slots, one per barrier plus fetch.
`define BP_QUEUE_DEPTH 4

// width of the global saturating counter.
`define BP_COUNTER_BITS 2

`endif

//--- source/branch_prediction_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "branch_params.svh"

module branch_prediction_queue (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   stall,

    input  logic                   push,
    input  logic                   push_taken,
    input  lc3b_isa_pkg::lc3b_word push_fallback,
    input  logic                   pop,
    input  logic                   clear,

    output logic                   head_taken,
    output lc3b_isa_pkg::lc3b_word head_fallback
);

    import lc3b_isa_pkg::*;
    import branch_ctrl_pkg::*;

    localparam int unsigned cnt_w = $clog2(`BP_QUEUE_DEPTH) + 1;

    typedef logic [cnt_w-1:0] qcount_t;

    logic     taken_mem [`BP_QUEUE_DEPTH];
    lc3b_word fallback_mem [`BP_QUEUE_DEPTH];

    bp_qptr_t rd_ptr;
    bp_qptr_t wr_ptr;
    qcount_t  count;
    logic     full;
    logic     empty;

    function automatic bp_qptr_t next_ptr(input bp_qptr_t ptr);
        if (ptr == bp_qptr_t'(`BP_QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + bp_qptr_t'(1);
    endfunction

    assign full  = (count == qcount_t'(`BP_QUEUE_DEPTH));
    assign empty = (count == '0);

    // clear wins, so a pop in the same cycle still leaves it empty.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (!stall) begin
            if (clear) begin
                rd_ptr <= '0;
                wr_ptr <= '0;
                count  <= '0;
            end else begin
                if (push) begin
                    wr_ptr <= next_ptr(wr_ptr);
                end
                if (pop) begin
                    rd_ptr <= next_ptr(rd_ptr);
                end
                if (push && !pop) begin
                    count <= count + qcount_t'(1);
                end else if (pop && !push) begin
                    count <= count - qcount_t'(1);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && push) begin
            taken_mem[wr_ptr]    <= push_taken;
            fallback_mem[wr_ptr] <= push_fallback;
        end
    end

    assign head_taken    = taken_mem[rd_ptr];
    assign head_fallback = fallback_mem[rd_ptr];

    // more brs in flight than pipeline slots.
    a_no_overflow: assert property (
        @(posedge clk) disable iff (!rst_n)
        (push && !stall) |-> (!full || pop)
    ) else $error("prediction queue push while full");

    // a br resolved that was never fetched.
    a_no_underflow: assert property (
        @(posedge clk) disable iff (!rst_n)
        (pop && !stall) |-> !empty
    ) else $error("prediction queue pop while empty");

endmodule

`default_nettype wire

//--- source/fetch_branch_decode.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_branch_decode (
    input  lc3b_isa_pkg::lc3b_word if_ir,
    input  lc3b_isa_pkg::lc3b_word if_pc,
    input  logic                   if_valid,

    output lc3b_isa_pkg::lc3b_word pc_plus2,
    output lc3b_isa_pkg::lc3b_word branch_target,
    output logic                   if_is_br
);

    import lc3b_isa_pkg::*;

    lc3b_opcode  if_opcode;
    lc3b_offset9 offset9;
    lc3b_word    byte_offset;

    assign if_opcode = lc3b_opcode'(if_ir[15:12]);
    assign offset9   = if_ir[8:0];

    // word offset to bytes, sign kept.
    assign byte_offset = {{6{offset9[8]}}, offset9, 1'b0};

    assign pc_plus2      = if_pc + 16'd2;
    assign branch_target = pc_plus2 + byte_offset;

    assign if_is_br = if_valid && (if_opcode == op_br);

endmodule

`default_nettype wire

//--- source/lc3b_branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module lc3b_branch_unit (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            stall,

    input  lc3b_isa_pkg::lc3b_word          if_ir,
    input  lc3b_isa_pkg::lc3b_word          if_pc,
    input  logic                            if_valid,

    input  lc3b_isa_pkg::lc3b_opcode        if_id_opcode,
    input  logic                            if_id_valid,

    input  lc3b_isa_pkg::lc3b_opcode        id_ex_opcode,
    input  logic                            id_ex_valid,

    input  lc3b_isa_pkg::lc3b_word          ex_mem_alu,
    input  lc3b_isa_pkg::lc3b_word          ex_mem_pcn,
    input  branch_ctrl_pkg::lc3b_pc_mux_sel ex_mem_pc_sel,
    input  lc3b_isa_pkg::lc3b_opcode        ex_mem_opcode,
    input  logic                            ex_mem_valid,

    input  logic                            mem_br_en,

    input  lc3b_isa_pkg::lc3b_word          mem_wb_mdr,
    input  branch_ctrl_pkg::lc3b_pc_mux_sel mem_wb_pc_sel,
    input  lc3b_isa_pkg::lc3b_opcode        mem_wb_opcode,
    input  logic                            mem_wb_valid,

    output lc3b_isa_pkg::lc3b_word          pc_next,
    output lc3b_isa_pkg::lc3b_word          pc_plus2,
    output logic                            flush_if_id,
    output logic                            flush_id_ex,
    output logic                            flush_ex_mem,
    output logic                            flush_mem_wb,
    output logic                            predict_hit,
    output logic                            predict_miss
);

    import lc3b_isa_pkg::*;

    lc3b_word branch_target;
    logic     if_is_br;

    logic     predict_taken;
    logic     train;
    logic     train_taken;

    logic     push;
    logic     push_taken;
    lc3b_word push_fallback;
    logic     pop;
    logic     clear;
    logic     head_taken;
    lc3b_word head_fallback;

    fetch_branch_decode u_decode (
        .if_ir         (if_ir),
        .if_pc         (if_pc),
        .if_valid      (if_valid),
        .pc_plus2      (pc_plus2),
        .branch_target (branch_target),
        .if_is_br      (if_is_br)
    );

    branch_history_counter u_counter (
        .clk           (clk),
        .rst_n         (rst_n),
        .stall         (stall),
        .train         (train),
        .train_taken   (train_taken),
        .predict_taken (predict_taken)
    );

    branch_prediction_queue u_queue (
        .clk           (clk),
        .rst_n         (rst_n),
        .stall         (stall),
        .push          (push),
        .push_taken    (push_taken),
        .push_fallback (push_fallback),
        .pop           (pop),
        .clear         (clear),
        .head_taken    (head_taken),
        .head_fallback (head_fallback)
    );

    redirect_resolver u_resolver (
        .if_id_opcode  (if_id_opcode),
        .if_id_valid   (if_id_valid),
        .id_ex_opcode  (id_ex_opcode),
        .id_ex_valid   (id_ex_valid),
        .ex_mem_alu    (ex_mem_alu),
        .ex_mem_pcn    (ex_mem_pcn),
        .ex_mem_pc_sel (ex_mem_pc_sel),
        .ex_mem_opcode (ex_mem_opcode),
        .ex_mem_valid  (ex_mem_valid),
        .mem_br_en     (mem_br_en),
        .mem_wb_mdr    (mem_wb_mdr),
        .mem_wb_pc_sel (mem_wb_pc_sel),
        .mem_wb_opcode (mem_wb_opcode),
        .mem_wb_valid  (mem_wb_valid),
        .pc_plus2      (pc_plus2),
        .branch_target (branch_target),
        .if_is_br      (if_is_br),
        .predict_taken (predict_taken),
        .head_taken    (head_taken),
        .head_fallback (head_fallback),
        .pc_next       (pc_next),
        .flush_if_id   (flush_if_id),
        .flush_id_ex   (flush_id_ex),
        .flush_ex_mem  (flush_ex_mem),
        .flush_mem_wb  (flush_mem_wb),
        .predict_hit   (predict_hit),
        .predict_miss  (predict_miss),
        .train         (train),
        .train_taken   (train_taken),
        .push          (push),
        .push_taken    (push_taken),
        .push_fallback (push_fallback),
        .pop           (pop),
        .clear         (clear)
    );

endmodule

`default_nettype wire

//--- source/lc3b_isa_pkg.sv
`default_nettype none

package lc3b_isa_pkg;

    // address or data word.
    typedef logic [15:0] lc3b_word;

    // ir[15:12].
    typedef enum logic [3:0] {
        op_br   = 4'd0,
        op_add  = 4'd1,
        op_ldb  = 4'd2,
        op_stb  = 4'd3,
        op_jsr  = 4'd4,
        op_and  = 4'd5,
        op_ldr  = 4'd6,
        op_str  = 4'd7,
        op_rti  = 4'd8,
        op_not  = 4'd9,
        op_ldi  = 4'd10,
        op_sti  = 4'd11,
        op_jmp  = 4'd12,
        op_shf  = 4'd13,
        op_lea  = 4'd14,
        op_trap = 4'd15
    } lc3b_opcode;

    // ir[8:0] of a br, in words.
    typedef logic [8:0] lc3b_offset9;

endpackage

`default_nettype wire

//--- source/redirect_resolver.sv
`timescale 1ns/1ps
`default_nettype none

module redirect_resolver (
    input  lc3b_isa_pkg::lc3b_opcode        if_id_opcode,
    input  logic                            if_id_valid,

    input  lc3b_isa_pkg::lc3b_opcode        id_ex_opcode,
    input  logic                            id_ex_valid,

    input  lc3b_isa_pkg::lc3b_word          ex_mem_alu,
    input  lc3b_isa_pkg::lc3b_word          ex_mem_pcn,
    input  branch_ctrl_pkg::lc3b_pc_mux_sel ex_mem_pc_sel,
    input  lc3b_isa_pkg::lc3b_opcode        ex_mem_opcode,
    input  logic                            ex_mem_valid,

    input  logic                            mem_br_en,

    input  lc3b_isa_pkg::lc3b_word          mem_wb_mdr,
    input  branch_ctrl_pkg::lc3b_pc_mux_sel mem_wb_pc_sel,
    input  lc3b_isa_pkg::lc3b_opcode        mem_wb_opcode,
    input  logic                            mem_wb_valid,

    input  lc3b_isa_pkg::lc3b_word          pc_plus2,
    input  lc3b_isa_pkg::lc3b_word          branch_target,
    input  logic                            if_is_br,
    input  logic                            predict_taken,
    input  logic                            head_taken,
    input  lc3b_isa_pkg::lc3b_word          head_fallback,

    output lc3b_isa_pkg::lc3b_word          pc_next,
    output logic                            flush_if_id,
    output logic                            flush_id_ex,
    output logic                            flush_ex_mem,
    output logic                            flush_mem_wb,
    output logic                            predict_hit,
    output logic                            predict_miss,

    output logic                            train,
    output logic                            train_taken,
    output logic                            push,
    output logic                            push_taken,
    output lc3b_isa_pkg::lc3b_word          push_fallback,
    output logic                            pop,
    output logic                            clear
);

    import lc3b_isa_pkg::*;
    import branch_ctrl_pkg::*;

    logic           if_id_jump;
    logic           id_ex_jump;
    logic           ex_mem_jump;
    logic           mem_wb_trap;
    logic           ex_mem_br;
    lc3b_pc_mux_sel pc_sel;

    function automatic logic is_jump(input lc3b_opcode op);
        return (op == op_jmp) || (op == op_jsr) || (op == op_trap);
    endfunction

    assign if_id_jump  = if_id_valid && is_jump(if_id_opcode);
    assign id_ex_jump  = id_ex_valid && is_jump(id_ex_opcode);
    assign ex_mem_jump = ex_mem_valid && is_jump(ex_mem_opcode);
    assign mem_wb_trap = mem_wb_valid && (mem_wb_opcode == op_trap);
    assign ex_mem_br   = ex_mem_valid && (ex_mem_opcode == op_br);

    assign predict_hit  = ex_mem_br && (head_taken == mem_br_en);
    assign predict_miss = ex_mem_br && (head_taken != mem_br_en);

    // each flush covers the barriers younger than the redirect.
    assign flush_mem_wb = mem_wb_trap;
    assign flush_ex_mem = flush_mem_wb | ex_mem_jump | predict_miss;
    assign flush_id_ex  = flush_ex_mem | id_ex_jump;
    assign flush_if_id  = flush_id_ex | if_id_jump;

    assign train       = ex_mem_br;
    assign train_taken = mem_br_en;
    assign pop         = ex_mem_br;

    // any flush kills every unresolved br.
    assign clear = flush_if_id;

    assign push          = if_is_br && !flush_if_id;
    assign push_taken    = predict_taken;
    assign push_fallback = predict_taken ? pc_plus2 : branch_target;

    // lowest priority first.
    always_comb begin
        pc_sel = branch_ctrl_pkg::pc_plus2;
        if (push && predict_taken) begin
            pc_sel = branch_address;
        end
        if (ex_mem_jump && (ex_mem_opcode != op_trap)) begin
            pc_sel = ex_mem_pc_sel;
        end
        if (mem_wb_trap) begin
            pc_sel = mem_wb_pc_sel;
        end
        if (predict_hit) begin
            pc_sel = branch_ctrl_pkg::pc_plus2;
        end else if (predict_miss) begin
            pc_sel = mispredict_address;
        end
    end

    always_comb begin
        case (pc_sel)
            branch_ctrl_pkg::pc_plus2: pc_next = pc_plus2;
            alu:                       pc_next = ex_mem_alu;
            pcn:                       pc_next = ex_mem_pcn;
            mdr:                       pc_next = mem_wb_mdr;
            branch_address:            pc_next = branch_target;
            mispredict_address:        pc_next = head_fallback;
            default:                   pc_next = pc_plus2;
        endcase
    end

    // a jmp or jsr in EX/MEM targets the alu or pcn value.
    always_comb begin
        if (ex_mem_jump && (ex_mem_opcode != op_trap)) begin
            a_jump_sel_valid: assert (ex_mem_pc_sel inside {alu, pcn})
                else $error("jmp or jsr in EX/MEM selects neither alu nor pcn");
        end
    end

endmodule

`default_nettype wire

//--- tb/lc3b_branch_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lc3b_branch_unit_tb;

    import lc3b_isa_pkg::*;

    // reset, then the six tests in order, then slack.
    localparam int cycle_limit = 5 + 9 + 4 + 10 + 12 + 5 + 9 + 20;

    logic clk, rst_n, stall;
    lc3b_word if_ir, if_pc, ex_mem_alu, ex_mem_pcn, mem_wb_mdr, pc_next, pc_plus2;
    lc3b_opcode if_id_opcode, id_ex_opcode, ex_mem_opcode, mem_wb_opcode;
    branch_ctrl_pkg::lc3b_pc_mux_sel ex_mem_pc_sel, mem_wb_pc_sel;
    logic if_valid, if_id_valid, id_ex_valid, ex_mem_valid, mem_wb_valid, mem_br_en;
    logic flush_if_id, flush_id_ex, flush_ex_mem, flush_mem_wb, predict_hit, predict_miss;

    // reference model of the counter and the fallback queue.
    int         model_count = 1;
    logic       taken_q[$];
    lc3b_word   fallback_q[$];
    logic       head_taken_m = 1'b0;
    lc3b_word   head_fallback_m = '0;

    lc3b_word   exp_pc_plus2, exp_target, exp_pc_next;
    logic [3:0] exp_flush;
    logic       exp_hit, exp_miss, exp_push, fetch_is_br, resolve_is_br, pred_taken_m;

    lc3b_opcode jump_ops[3] = '{op_jmp, op_jsr, op_trap};
    int         error_count = 0;
    int         test_count = 0;
    int         cycle_count = 0;
    integer     seed = 65;

    lc3b_branch_unit DUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic is_redirect_op(input lc3b_opcode op);
        return (op == op_jmp) || (op == op_jsr) || (op == op_trap);
    endfunction

    function automatic lc3b_word pick_source(input branch_ctrl_pkg::lc3b_pc_mux_sel sel,
            input lc3b_word plus2, input lc3b_word alu_w, input lc3b_word pcn_w,
            input lc3b_word mdr_w);
        case (sel)
            branch_ctrl_pkg::alu: return alu_w;
            branch_ctrl_pkg::pcn: return pcn_w;
            branch_ctrl_pkg::mdr: return mdr_w;
            default: return plus2;
        endcase
    endfunction

    // redirect rules, lowest priority first.
    always_comb begin
        pred_taken_m = (model_count >= 2);
        exp_pc_plus2 = if_pc + 16'd2;
        exp_target = lc3b_word'(int'(if_pc) + 2 + 2 * $signed(if_ir[8:0]));
        fetch_is_br = if_valid && (if_ir[15:12] == 4'd0);
        resolve_is_br = ex_mem_valid && (ex_mem_opcode == op_br);
        exp_hit = resolve_is_br && (head_taken_m == mem_br_en);
        exp_miss = resolve_is_br && (head_taken_m != mem_br_en);
        exp_flush = 4'b0000;
        if (if_id_valid && is_redirect_op(if_id_opcode)) begin
            exp_flush = 4'b1000;
        end
        if (id_ex_valid && is_redirect_op(id_ex_opcode)) begin
            exp_flush = exp_flush | 4'b1100;
        end
        if ((ex_mem_valid && is_redirect_op(ex_mem_opcode)) || exp_miss) begin
            exp_flush = exp_flush | 4'b1110;
        end
        if (mem_wb_valid && (mem_wb_opcode == op_trap)) begin
            exp_flush = 4'b1111;
        end
        exp_push = fetch_is_br && (exp_flush == 4'b0000);
        exp_pc_next = exp_pc_plus2;
        if (exp_push && pred_taken_m) begin
            exp_pc_next = exp_target;
        end
        if (ex_mem_valid && (ex_mem_opcode == op_jmp || ex_mem_opcode == op_jsr)) begin
            exp_pc_next = pick_source(ex_mem_pc_sel, exp_pc_plus2, ex_mem_alu, ex_mem_pcn,
                                      mem_wb_mdr);
        end
        if (mem_wb_valid && (mem_wb_opcode == op_trap)) begin
            exp_pc_next = pick_source(mem_wb_pc_sel, exp_pc_plus2, ex_mem_alu, ex_mem_pcn,
                                      mem_wb_mdr);
        end
        if (exp_hit) begin
            exp_pc_next = exp_pc_plus2;
        end else if (exp_miss) begin
            exp_pc_next = head_fallback_m;
        end
    end

    always @(posedge clk) begin : model_update
        logic     push_taken_v;
        lc3b_word push_fallback_v;
        push_taken_v = pred_taken_m;
        push_fallback_v = pred_taken_m ? exp_pc_plus2 : exp_target;
        if (!rst_n) begin
            model_count = 1;
            taken_q.delete();
            fallback_q.delete();
        end else if (!stall) begin
            if (resolve_is_br) begin
                model_count = mem_br_en ? model_count + (model_count < 3)
                                        : model_count - (model_count > 0);
                if (taken_q.size() != 0) begin
                    void'(taken_q.pop_front());
                    void'(fallback_q.pop_front());
                end
            end
            if (exp_flush != 4'b0000) begin
                taken_q.delete();
                fallback_q.delete();
            end else if (exp_push) begin
                taken_q.push_back(push_taken_v);
                fallback_q.push_back(push_fallback_v);
            end
        end
        head_taken_m = (taken_q.size() != 0) ? taken_q[0] : 1'b0;
        head_fallback_m = (fallback_q.size() != 0) ? fallback_q[0] : '0;
    end

    task automatic report_mismatch(input string what, input lc3b_word got, input lc3b_word want);
        error_count++;
        $display("Fail at %0t: %s is %h, expected %h", $time, what, got, want);
    endtask

    a_pc_plus2: assert property (@(posedge clk) disable iff (!rst_n)
        pc_plus2 == exp_pc_plus2)
        else report_mismatch("pc_plus2", $sampled(pc_plus2), $sampled(exp_pc_plus2));

    a_pc_next: assert property (@(posedge clk) disable iff (!rst_n)
        pc_next == exp_pc_next)
        else report_mismatch("pc_next", $sampled(pc_next), $sampled(exp_pc_next));

    // four flushes, then hit and miss.
    a_flags: assert property (@(posedge clk) disable iff (!rst_n)
        {flush_if_id, flush_id_ex, flush_ex_mem, flush_mem_wb, predict_hit, predict_miss}
            == {exp_flush, exp_hit, exp_miss})
        else report_mismatch("flush and predict flags",
            lc3b_word'($sampled({flush_if_id, flush_id_ex, flush_ex_mem, flush_mem_wb,
                                 predict_hit, predict_miss})),
            lc3b_word'($sampled({exp_flush, exp_hit, exp_miss})));

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout: the run did not end within %0d cycles", cycle_limit);
            $display("Checks failed");
            $finish;
        end
    end

    // all barriers empty, a plain add in fetch.
    task automatic set_quiet_inputs();
        {stall, if_id_valid, id_ex_valid, ex_mem_valid, mem_wb_valid, mem_br_en} = '0;
        if_id_opcode = op_add;
        id_ex_opcode = op_add;
        ex_mem_opcode = op_add;
        mem_wb_opcode = op_add;
        ex_mem_pc_sel = branch_ctrl_pkg::pc_plus2;
        mem_wb_pc_sel = branch_ctrl_pkg::pc_plus2;
        {ex_mem_alu, ex_mem_pcn, mem_wb_mdr} = '0;
        if_valid = 1'b1;
        if_pc = 16'($random(seed)) & 16'hfffe;
        if_ir = {4'd1, 12'($random(seed))};
    endtask

    task automatic run_cycle();
        @(posedge clk);
        #1;
        set_quiet_inputs();
    endtask

    task automatic put_br_in_fetch();
        if_ir = {4'd0, 3'b111, 9'($random(seed))};
    endtask

    task automatic put_br_in_ex_mem(input logic taken);
        ex_mem_valid = 1'b1;
        ex_mem_opcode = op_br;
        mem_br_en = taken;
    endtask

    task automatic end_test(input string name);
        test_count++;
        $display("test %0d (%s) done, %0d errors so far", test_count, name, error_count);
    endtask

    initial begin
        rst_n = 1'b0;
        set_quiet_inputs();
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;

        repeat (8) run_cycle();
        put_br_in_fetch();
        if_valid = 1'b0;
        run_cycle();
        end_test("sequential fetch");

        // weakly not taken after reset, so a taken outcome mispredicts.
        put_br_in_fetch();
        run_cycle();
        repeat (2) run_cycle();
        put_br_in_ex_mem(1'b1);
        run_cycle();
        end_test("first br mispredict");

        repeat (3) begin
            put_br_in_fetch();
            run_cycle();
        end
        put_br_in_fetch();
        put_br_in_ex_mem(1'b1);
        run_cycle();
        put_br_in_ex_mem(1'b1);
        run_cycle();
        put_br_in_ex_mem(1'b0);
        run_cycle();
        put_br_in_fetch();
        run_cycle();
        put_br_in_ex_mem(1'b0);
        run_cycle();
        put_br_in_fetch();
        run_cycle();
        put_br_in_ex_mem(1'b0);
        run_cycle();
        end_test("brs in flight");

        for (int stage = 0; stage < 4; stage++) begin
            foreach (jump_ops[i]) begin
                case (stage)
                    0: begin
                        if_id_valid = 1'b1;
                        if_id_opcode = jump_ops[i];
                        put_br_in_fetch();
                    end
                    1: begin
                        id_ex_valid = 1'b1;
                        id_ex_opcode = jump_ops[i];
                    end
                    2: begin
                        ex_mem_alu = 16'($random(seed));
                        ex_mem_pcn = 16'($random(seed));
                        ex_mem_pc_sel = (i == 1) ? branch_ctrl_pkg::pcn : branch_ctrl_pkg::alu;
                        ex_mem_valid = 1'b1;
                        ex_mem_opcode = jump_ops[i];
                    end
                    default: begin
                        mem_wb_valid = 1'b1;
                        mem_wb_opcode = jump_ops[i];
                        mem_wb_mdr = 16'($random(seed));
                        mem_wb_pc_sel = branch_ctrl_pkg::mdr;
                    end
                endcase
                run_cycle();
            end
        end
        end_test("jmp jsr trap per barrier");

        // two brs lost to a jmp, then a fresh one resolves.
        repeat (2) begin
            put_br_in_fetch();
            run_cycle();
        end
        put_br_in_fetch();
        id_ex_valid = 1'b1;
        id_ex_opcode = op_jmp;
        run_cycle();
        put_br_in_fetch();
        run_cycle();
        put_br_in_ex_mem(1'b1);
        run_cycle();
        end_test("redirect clears queue");

        put_br_in_fetch();
        run_cycle();
        stall = 1'b1;
        put_br_in_fetch();
        put_br_in_ex_mem(1'b1);
        run_cycle();
        stall = 1'b1;
        ex_mem_pc_sel = branch_ctrl_pkg::alu;
        ex_mem_valid = 1'b1;
        ex_mem_opcode = op_jmp;
        run_cycle();
        stall = 1'b1;
        put_br_in_ex_mem(1'b1);
        run_cycle();
        put_br_in_ex_mem(1'b1);
        run_cycle();
        put_br_in_fetch();
        run_cycle();
        put_br_in_ex_mem(1'b0);
        run_cycle();
        put_br_in_fetch();
        run_cycle();
        put_br_in_ex_mem(1'b0);
        run_cycle();
        end_test("stall freezes state");

        $display("%0d tests run, %0d errors", test_count, error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
